//--- Makefile
SIM = obj_dir/Vmem_map_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module mem_map_tb -f all.f -Mdir obj_dir -o Vmem_map_tb

run: compile
	./$(SIM) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- all.f
+incdir+include
logic/agc_mem_map_pkg.sv
logic/agc_pipe_pkg.sv
logic/bank_regs.sv
logic/region_classify.sv
logic/phys_addr_gen.sv
logic/mem_map_top.sv
verif/mem_map_tb.sv

//--- logic/agc_mem_map_pkg.sv
package agc_mem_map_pkg;

  // Machine word and address widths
  localparam int word_w      = 15;
  localparam int soft_addr_w = 12;
  localparam int rom_addr_w  = 14;
  localparam int ram_addr_w  = 11;
  localparam int bank_bits_w = 3;

  // Bank field positions inside a written word
  // EB sits in bits 11..9
  localparam int eb_lsb = 9;
  // FB sits in bits 14..12
  localparam int fb_lsb = 12;

  // Software address as seen by the program
  typedef logic [soft_addr_w-1:0] soft_addr_t;

  // Physical ROM address, 16 banks worth of space
  typedef logic [rom_addr_w-1:0] rom_addr_t;

  // Physical erasable memory address
  typedef logic [ram_addr_w-1:0] ram_addr_t;

  // One bank register field
  typedef logic [bank_bits_w-1:0] bank_bits_t;

  // Software region boundaries, all octal
  // Fixed RAM below this, banked RAM from here
  localparam soft_addr_t ram_fixed_top   = 12'o1400;
  // First address of the ROM half of the map
  localparam soft_addr_t rom_region_base = 12'o2000;
  // Fixed ROM from here up to the top
  localparam soft_addr_t rom_fixed_base  = 12'o4000;

  // Size of one erasable bank
  localparam ram_addr_t ram_bank_size = 11'o0400;

  // Size of one fixed bank
  localparam rom_addr_t rom_bank_size = 14'o02000;

  // Offset forced when the top EB bit is set
  localparam ram_addr_t ram_high_bank_offset = 11'o2000;

endpackage : agc_mem_map_pkg

//--- logic/agc_pipe_pkg.sv
package agc_pipe_pkg;

  // Stage count from lookup to result
  localparam int pipe_latency = 3;

  // Target of a bank register write
  typedef enum logic [1:0] {
    bank_eb = 2'd0,
    bank_fb = 2'd1,
    bank_bb = 2'd2
  } bank_sel_t;

  // Memory regions
  // Top bit set means ROM
  typedef enum logic [1:0] {
    reg_ram_fixed  = 2'b00,
    reg_ram_banked = 2'b01,
    reg_rom_banked = 2'b10,
    reg_rom_fixed  = 2'b11
  } region_t;

  // First stage payload, 18 bits
  typedef struct packed {
    agc_mem_map_pkg::soft_addr_t addr;
    agc_mem_map_pkg::bank_bits_t eb;
    agc_mem_map_pkg::bank_bits_t fb;
  } lookup_t;

  // Second stage payload
  typedef struct packed {
    region_t                     region;
    agc_mem_map_pkg::rom_addr_t  norm_off;
    agc_mem_map_pkg::rom_addr_t  bank_off;
  } classed_t;

  // RAM address with zero fill up to the ROM width
  typedef struct packed {
    logic [agc_mem_map_pkg::rom_addr_w-agc_mem_map_pkg::ram_addr_w-1:0] pad;
    agc_mem_map_pkg::ram_addr_t                                          ram;
  } ram_view_t;

  // Final physical address word
  // Same bits read as ROM or as padded RAM
  typedef union packed {
    agc_mem_map_pkg::rom_addr_t rom;
    ram_view_t                  ram_view;
  } phys_addr_u;

endpackage : agc_pipe_pkg

//--- logic/bank_regs.sv
`timescale 1ns/1ps

module bank_regs (
  input  logic                                  clk,
  input  logic                                  rst_l,
  input  logic                                  bank_wr_en,
  input  agc_pipe_pkg::bank_sel_t               bank_wr_sel,
  input  logic [agc_mem_map_pkg::word_w-1:0]    bank_wr_data,
  input  logic                                  lookup_valid,
  input  agc_mem_map_pkg::soft_addr_t           lookup_addr,
  output logic                                  s1_valid,
  output agc_pipe_pkg::lookup_t                 s1,
  output agc_mem_map_pkg::bank_bits_t           bank_eb,
  output agc_mem_map_pkg::bank_bits_t           bank_fb
);

  // Fields pulled out of the write word
  agc_mem_map_pkg::bank_bits_t wr_eb;
  agc_mem_map_pkg::bank_bits_t wr_fb;

  // Bank values after this cycle's write
  agc_mem_map_pkg::bank_bits_t eb_next;
  agc_mem_map_pkg::bank_bits_t fb_next;

  logic eb_hit;
  logic fb_hit;

  always_comb begin
    wr_eb = bank_wr_data[agc_mem_map_pkg::eb_lsb +: agc_mem_map_pkg::bank_bits_w];
    wr_fb = bank_wr_data[agc_mem_map_pkg::fb_lsb +: agc_mem_map_pkg::bank_bits_w];

    // BB write touches both fields
    eb_hit = bank_wr_en && ((bank_wr_sel == agc_pipe_pkg::bank_eb) ||
                            (bank_wr_sel == agc_pipe_pkg::bank_bb));
    fb_hit = bank_wr_en && ((bank_wr_sel == agc_pipe_pkg::bank_fb) ||
                            (bank_wr_sel == agc_pipe_pkg::bank_bb));

    // Forward the write so a same-cycle lookup sees it
    eb_next = eb_hit ? wr_eb : bank_eb;
    fb_next = fb_hit ? wr_fb : bank_fb;
  end

  // Bank register file, only the selected field moves
  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      bank_eb <= '0;
      bank_fb <= '0;
    end else begin
      bank_eb <= eb_next;
      bank_fb <= fb_next;
    end
  end

  // Stage 1 valid
  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= lookup_valid;
    end
  end

  // Lookup captured along with the forwarded banks
  always_ff @(posedge clk) begin
    if (lookup_valid) begin
      s1.addr <= lookup_addr;
      s1.eb   <= eb_next;
      s1.fb   <= fb_next;
    end
  end

  // Only EB, FB and BB are real bank targets
  a_legal_sel : assert property (@(posedge clk) disable iff (!rst_l)
    bank_wr_en |-> (bank_wr_sel inside {agc_pipe_pkg::bank_eb,
                                        agc_pipe_pkg::bank_fb,
                                        agc_pipe_pkg::bank_bb}));

endmodule : bank_regs

//--- logic/mem_map_top.sv
`timescale 1ns/1ps

module mem_map_top (
  input  logic                               clk,
  input  logic                               rst_l,
  input  logic                               bank_wr_en,
  input  agc_pipe_pkg::bank_sel_t            bank_wr_sel,
  input  logic [agc_mem_map_pkg::word_w-1:0] bank_wr_data,
  input  logic                               lookup_valid,
  input  agc_mem_map_pkg::soft_addr_t        lookup_addr,
  output logic                               out_valid,
  output logic                               out_is_rom,
  output agc_pipe_pkg::phys_addr_u           out_addr,
  output agc_mem_map_pkg::bank_bits_t        bank_eb,
  output agc_mem_map_pkg::bank_bits_t        bank_fb
);

  // Stage 1 to stage 2
  logic                   s1_valid;
  agc_pipe_pkg::lookup_t  s1;

  // Stage 2 to stage 3
  logic                   s2_valid;
  agc_pipe_pkg::classed_t s2;

  bank_regs u_bank_regs (
    .clk          (clk),
    .rst_l        (rst_l),
    .bank_wr_en   (bank_wr_en),
    .bank_wr_sel  (bank_wr_sel),
    .bank_wr_data (bank_wr_data),
    .lookup_valid (lookup_valid),
    .lookup_addr  (lookup_addr),
    .s1_valid     (s1_valid),
    .s1           (s1),
    .bank_eb      (bank_eb),
    .bank_fb      (bank_fb)
  );

  region_classify u_region_classify (
    .clk      (clk),
    .rst_l    (rst_l),
    .s1_valid (s1_valid),
    .s1       (s1),
    .s2_valid (s2_valid),
    .s2       (s2)
  );

  phys_addr_gen u_phys_addr_gen (
    .clk        (clk),
    .rst_l      (rst_l),
    .s2_valid   (s2_valid),
    .s2         (s2),
    .out_valid  (out_valid),
    .out_is_rom (out_is_rom),
    .out_addr   (out_addr)
  );

endmodule : mem_map_top

//--- logic/phys_addr_gen.sv
`timescale 1ns/1ps

module phys_addr_gen (
  input  logic                     clk,
  input  logic                     rst_l,
  input  logic                     s2_valid,
  input  agc_pipe_pkg::classed_t   s2,
  output logic                     out_valid,
  output logic                     out_is_rom,
  output agc_pipe_pkg::phys_addr_u out_addr
);

  // Full-width sum, wraps at 14 bits for ROM
  agc_mem_map_pkg::rom_addr_t sum;
  agc_mem_map_pkg::ram_addr_t ram_sum;
  agc_pipe_pkg::phys_addr_u   addr_next;
  logic                       is_rom;

  always_comb begin
    sum     = s2.norm_off + s2.bank_off;
    // RAM result keeps only the low 11 bits
    ram_sum = sum[agc_mem_map_pkg::ram_addr_w-1:0];

    // Region top bit picks the memory
    is_rom = s2.region[1];

    addr_next = '0;
    if (is_rom) begin
      addr_next.rom = sum;
    end else begin
      addr_next.ram_view.pad = '0;
      addr_next.ram_view.ram = ram_sum;
    end
  end

  // Output valid, one pulse per lookup
  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= s2_valid;
    end
  end

  // Result held until the next lookup lands
  always_ff @(posedge clk) begin
    if (s2_valid) begin
      out_is_rom <= is_rom;
      out_addr   <= addr_next;
    end
  end

  // Valid chain fully defined once out of reset
  a_valid_known : assert property (@(posedge clk) disable iff (!rst_l)
    !$isunknown(out_valid));

endmodule : phys_addr_gen

//--- logic/region_classify.sv
`timescale 1ns/1ps

module region_classify (
  input  logic                   clk,
  input  logic                   rst_l,
  input  logic                   s1_valid,
  input  agc_pipe_pkg::lookup_t  s1,
  output logic                   s2_valid,
  output agc_pipe_pkg::classed_t s2
);

  agc_pipe_pkg::region_t      region;
  agc_mem_map_pkg::rom_addr_t norm_off;
  agc_mem_map_pkg::rom_addr_t bank_off;
  agc_mem_map_pkg::rom_addr_t eb_off;
  agc_mem_map_pkg::rom_addr_t fb_off;

  always_comb begin
    // Region from the software address alone
    if (s1.addr < agc_mem_map_pkg::ram_fixed_top) begin
      region = agc_pipe_pkg::reg_ram_fixed;
    end else if (s1.addr < agc_mem_map_pkg::rom_region_base) begin
      region = agc_pipe_pkg::reg_ram_banked;
    end else if (s1.addr < agc_mem_map_pkg::rom_fixed_base) begin
      region = agc_pipe_pkg::reg_rom_banked;
    end else begin
      region = agc_pipe_pkg::reg_rom_fixed;
    end

    // Erasable bank offset table, no multiplier
    unique case (s1.eb[1:0])
      2'b00: eb_off = '0;
      2'b01: eb_off = agc_mem_map_pkg::rom_addr_t'(agc_mem_map_pkg::ram_bank_size);
      2'b10: eb_off = agc_mem_map_pkg::rom_addr_t'(2 * agc_mem_map_pkg::ram_bank_size);
      2'b11: eb_off = agc_mem_map_pkg::rom_addr_t'(3 * agc_mem_map_pkg::ram_bank_size);
    endcase
    // Top EB bit overrides the low two
    if (s1.eb[2]) begin
      eb_off = agc_mem_map_pkg::rom_addr_t'(agc_mem_map_pkg::ram_high_bank_offset);
    end

    // Fixed bank offset table
    unique case (s1.fb)
      3'd0: fb_off = '0;
      3'd1: fb_off = agc_mem_map_pkg::rom_bank_size;
      3'd2: fb_off = agc_mem_map_pkg::rom_addr_t'(2 * agc_mem_map_pkg::rom_bank_size);
      3'd3: fb_off = agc_mem_map_pkg::rom_addr_t'(3 * agc_mem_map_pkg::rom_bank_size);
      3'd4: fb_off = agc_mem_map_pkg::rom_addr_t'(4 * agc_mem_map_pkg::rom_bank_size);
      3'd5: fb_off = agc_mem_map_pkg::rom_addr_t'(5 * agc_mem_map_pkg::rom_bank_size);
      3'd6: fb_off = agc_mem_map_pkg::rom_addr_t'(6 * agc_mem_map_pkg::rom_bank_size);
      3'd7: fb_off = agc_mem_map_pkg::rom_addr_t'(7 * agc_mem_map_pkg::rom_bank_size);
    endcase

    // Normalized offset and bank offset per region
    unique case (region)
      agc_pipe_pkg::reg_ram_fixed: begin
        norm_off = agc_mem_map_pkg::rom_addr_t'(s1.addr[agc_mem_map_pkg::ram_addr_w-1:0]);
        bank_off = '0;
      end
      agc_pipe_pkg::reg_ram_banked: begin
        norm_off = agc_mem_map_pkg::rom_addr_t'(s1.addr[agc_mem_map_pkg::ram_addr_w-1:0]);
        bank_off = eb_off;
      end
      agc_pipe_pkg::reg_rom_banked: begin
        // Banked window lands above the two fixed-fixed banks
        norm_off = agc_mem_map_pkg::rom_addr_t'(s1.addr) +
                   agc_mem_map_pkg::rom_addr_t'(agc_mem_map_pkg::rom_region_base);
        bank_off = fb_off;
      end
      agc_pipe_pkg::reg_rom_fixed: begin
        norm_off = agc_mem_map_pkg::rom_addr_t'(s1.addr - agc_mem_map_pkg::rom_fixed_base);
        bank_off = '0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      s2.region   <= region;
      s2.norm_off <= norm_off;
      s2.bank_off <= bank_off;
    end
  end

  // Fixed regions never pick up bank bits
  a_fixed_no_bank : assert property (@(posedge clk) disable iff (!rst_l)
    (s2_valid && (s2.region inside {agc_pipe_pkg::reg_ram_fixed,
                                    agc_pipe_pkg::reg_rom_fixed}))
    |-> (s2.bank_off == '0));

endmodule : region_classify

//--- include/mem_map_vectors.svh
`ifndef MEM_MAP_VECTORS_SVH
`define MEM_MAP_VECTORS_SVH

// One directed cycle
// Expected fields only matter when lk_valid is set
typedef struct packed {
  logic                               wr_en;
  agc_pipe_pkg::bank_sel_t            wr_sel;
  logic [agc_mem_map_pkg::word_w-1:0] wr_data;
  logic                               lk_valid;
  agc_mem_map_pkg::soft_addr_t        lk_addr;
  logic                               exp_is_rom;
  agc_mem_map_pkg::rom_addr_t         exp_addr;
} vec_row_t;

localparam int num_vectors = 18;

// Bank state starts at EB 0, FB 0
localparam vec_row_t vectors [num_vectors] = '{
  // Fixed RAM top
  '{1'b0, agc_pipe_pkg::bank_eb, 15'o00000, 1'b1, 12'o1377, 1'b0, 14'o01377},
  // Fixed ROM bottom and top
  '{1'b0, agc_pipe_pkg::bank_eb, 15'o00000, 1'b1, 12'o4000, 1'b1, 14'o00000},
  '{1'b0, agc_pipe_pkg::bank_eb, 15'o00000, 1'b1, 12'o7777, 1'b1, 14'o03777},
  // EB 1 with same-cycle lookup
  '{1'b1, agc_pipe_pkg::bank_eb, 15'o01000, 1'b1, 12'o1400, 1'b0, 14'o02000},
  // FB 5 with same-cycle lookup
  '{1'b1, agc_pipe_pkg::bank_fb, 15'o50000, 1'b1, 12'o2000, 1'b1, 14'o16000},
  // EB still 1 after the FB write
  '{1'b0, agc_pipe_pkg::bank_eb, 15'o00000, 1'b1, 12'o1777, 1'b0, 14'o02377},
  // EB 4, top bit adds 2000
  '{1'b1, agc_pipe_pkg::bank_eb, 15'o04000, 1'b1, 12'o1400, 1'b0, 14'o03400},
  // FB still 5 after the EB write
  '{1'b0, agc_pipe_pkg::bank_eb, 15'o00000, 1'b1, 12'o3777, 1'b1, 14'o17777},
  // BB write, FB 2 and EB 3
  '{1'b1, agc_pipe_pkg::bank_bb, 15'o23000, 1'b1, 12'o1400, 1'b0, 14'o03000},
  '{1'b0, agc_pipe_pkg::bank_eb, 15'o00000, 1'b1, 12'o2000, 1'b1, 14'o10000},
  // EB 7, FB field of the word ignored
  '{1'b1, agc_pipe_pkg::bank_eb, 15'o07000, 1'b1, 12'o1777, 1'b0, 14'o03777},
  // FB 7, last word of the highest bank
  '{1'b1, agc_pipe_pkg::bank_fb, 15'o70000, 1'b1, 12'o3777, 1'b1, 14'o23777},
  // Write alone, no lookup
  '{1'b1, agc_pipe_pkg::bank_fb, 15'o00000, 1'b0, 12'o0000, 1'b0, 14'o00000},
  '{1'b0, agc_pipe_pkg::bank_eb, 15'o00000, 1'b1, 12'o2000, 1'b1, 14'o04000},
  // Fixed regions ignore live banks
  '{1'b0, agc_pipe_pkg::bank_eb, 15'o00000, 1'b1, 12'o5000, 1'b1, 14'o01000},
  '{1'b0, agc_pipe_pkg::bank_eb, 15'o00000, 1'b1, 12'o0000, 1'b0, 14'o00000},
  // BB with all ones, low data bits ignored
  '{1'b1, agc_pipe_pkg::bank_bb, 15'o77777, 1'b1, 12'o1400, 1'b0, 14'o03400},
  '{1'b0, agc_pipe_pkg::bank_eb, 15'o00000, 1'b1, 12'o1377, 1'b0, 14'o01377}
};

`endif

//--- verif/mem_map_tb.sv
`timescale 1ns/1ps

module mem_map_tb;

  `include "mem_map_vectors.svh"

  // One expected lookup result
  typedef struct packed {
    logic                       is_rom;
    agc_mem_map_pkg::rom_addr_t addr;
  } exp_t;

  localparam int rand_cycles = 200;
  // Table plus random phase plus drain, with slack
  localparam int cycle_limit = num_vectors + rand_cycles + agc_pipe_pkg::pipe_latency + 20;

  logic                               clk;
  logic                               rst_l;
  logic                               bank_wr_en;
  agc_pipe_pkg::bank_sel_t            bank_wr_sel;
  logic [agc_mem_map_pkg::word_w-1:0] bank_wr_data;
  logic                               lookup_valid;
  agc_mem_map_pkg::soft_addr_t        lookup_addr;
  logic                               out_valid;
  logic                               out_is_rom;
  agc_pipe_pkg::phys_addr_u           out_addr;
  agc_mem_map_pkg::bank_bits_t        bank_eb;
  agc_mem_map_pkg::bank_bits_t        bank_fb;

  // Results still in flight, oldest first
  exp_t   exp_q[$];
  int     error_count;
  int     result_count;
  int     cycle_count;
  integer seed;

  // Banks as the driver sees them, write applied at once
  agc_mem_map_pkg::bank_bits_t drv_eb;
  agc_mem_map_pkg::bank_bits_t drv_fb;

  // Banks as the outputs should show them
  agc_mem_map_pkg::bank_bits_t mon_eb;
  agc_mem_map_pkg::bank_bits_t mon_fb;

  // Lookup strobes of the last few cycles
  logic [agc_pipe_pkg::pipe_latency-1:0] launch_hist;

  mem_map_top UUT (
    .clk          (clk),
    .rst_l        (rst_l),
    .bank_wr_en   (bank_wr_en),
    .bank_wr_sel  (bank_wr_sel),
    .bank_wr_data (bank_wr_data),
    .lookup_valid (lookup_valid),
    .lookup_addr  (lookup_addr),
    .out_valid    (out_valid),
    .out_is_rom   (out_is_rom),
    .out_addr     (out_addr),
    .bank_eb      (bank_eb),
    .bank_fb      (bank_fb)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // EB after a write, bits 11..9 of the word
  function automatic agc_mem_map_pkg::bank_bits_t eb_after_write(
    input logic                               wr_en,
    input agc_pipe_pkg::bank_sel_t            sel,
    input logic [agc_mem_map_pkg::word_w-1:0] data,
    input agc_mem_map_pkg::bank_bits_t        eb
  );
    if (wr_en && (sel == agc_pipe_pkg::bank_eb || sel == agc_pipe_pkg::bank_bb)) begin
      return data[11:9];
    end
    return eb;
  endfunction

  // FB after a write, bits 14..12 of the word
  function automatic agc_mem_map_pkg::bank_bits_t fb_after_write(
    input logic                               wr_en,
    input agc_pipe_pkg::bank_sel_t            sel,
    input logic [agc_mem_map_pkg::word_w-1:0] data,
    input agc_mem_map_pkg::bank_bits_t        fb
  );
    if (wr_en && (sel == agc_pipe_pkg::bank_fb || sel == agc_pipe_pkg::bank_bb)) begin
      return data[14:12];
    end
    return fb;
  endfunction

  // Reference memory map
  function automatic exp_t expected_map(
    input agc_mem_map_pkg::soft_addr_t addr,
    input agc_mem_map_pkg::bank_bits_t eb,
    input agc_mem_map_pkg::bank_bits_t fb
  );
    exp_t        res;
    logic [13:0] bank_part;
    logic [13:0] sum;
    res = '0;
    if (addr < 12'o1400) begin
      res.addr = {3'b000, addr[10:0]};
    end else if (addr < 12'o2000) begin
      // EB times 400, or a flat 2000 for the upper banks
      bank_part = eb[2] ? 14'o2000 : {4'd0, eb[1:0], 8'd0};
      sum       = {3'b000, addr[10:0]} + bank_part;
      res.addr  = {3'b000, sum[10:0]};
    end else if (addr < 12'o4000) begin
      // FB times 2000 on top of the shifted window
      res.is_rom = 1'b1;
      res.addr   = {2'b00, addr} + 14'o2000 + {1'b0, fb, 10'd0};
    end else begin
      res.is_rom = 1'b1;
      res.addr   = {2'b00, addr} - 14'o4000;
    end
    return res;
  endfunction

  // One cycle of stimulus, expected result queued
  task automatic drive_row(input vec_row_t row);
    exp_t e;
    @(posedge clk);
    bank_wr_en   <= row.wr_en;
    bank_wr_sel  <= row.wr_sel;
    bank_wr_data <= row.wr_data;
    lookup_valid <= row.lk_valid;
    lookup_addr  <= row.lk_addr;
    drv_eb = eb_after_write(row.wr_en, row.wr_sel, row.wr_data, drv_eb);
    drv_fb = fb_after_write(row.wr_en, row.wr_sel, row.wr_data, drv_fb);
    if (row.lk_valid) begin
      e.is_rom = row.exp_is_rom;
      e.addr   = row.exp_addr;
      exp_q.push_back(e);
    end
  endtask

  // Random write and lookup, expected value from the model
  task automatic drive_random();
    vec_row_t                    row;
    exp_t                        e;
    logic [1:0]                  sel_raw;
    agc_mem_map_pkg::bank_bits_t eb_n;
    agc_mem_map_pkg::bank_bits_t fb_n;
    row         = '0;
    sel_raw     = 2'({$random(seed)} % 3);
    row.wr_en   = (($random(seed) & 3) == 0);
    row.wr_sel  = agc_pipe_pkg::bank_sel_t'(sel_raw);
    row.wr_data = 15'($random(seed));
    row.lk_valid = (($random(seed) & 3) != 0);
    row.lk_addr = 12'($random(seed));
    // Same-cycle write is seen by the lookup
    eb_n = eb_after_write(row.wr_en, row.wr_sel, row.wr_data, drv_eb);
    fb_n = fb_after_write(row.wr_en, row.wr_sel, row.wr_data, drv_fb);
    e    = expected_map(row.lk_addr, eb_n, fb_n);
    row.exp_is_rom = e.is_rom;
    row.exp_addr   = e.addr;
    drive_row(row);
  endtask

  // Checks on the falling edge, outputs settled
  always @(negedge clk) begin
    exp_t e;
    assert (bank_eb === mon_eb) else begin
      $display("** Error at %0t: bank_eb expected %0o, got %0o", $time, mon_eb, bank_eb);
      error_count++;
    end
    assert (bank_fb === mon_fb) else begin
      $display("** Error at %0t: bank_fb expected %0o, got %0o", $time, mon_fb, bank_fb);
      error_count++;
    end
    // Result exactly pipe_latency cycles after its lookup
    assert (out_valid === launch_hist[agc_pipe_pkg::pipe_latency-1]) else begin
      $display("** Error at %0t: out_valid expected %b, got %b", $time,
               launch_hist[agc_pipe_pkg::pipe_latency-1], out_valid);
      error_count++;
    end
    if (out_valid === 1'b1) begin
      assert (exp_q.size() > 0) else begin
        $display("Result at %0t came out with no lookup outstanding", $time);
        error_count++;
      end
      if (exp_q.size() > 0) begin
        e = exp_q.pop_front();
        result_count++;
        assert (out_is_rom === e.is_rom) else begin
          $display("** Error at %0t: out_is_rom expected %b, got %b", $time,
                   e.is_rom, out_is_rom);
          error_count++;
        end
        assert (out_addr.rom === e.addr) else begin
          $display("** Error at %0t: out_addr expected %05o, got %05o", $time,
                   e.addr, out_addr.rom);
          error_count++;
        end
      end
    end
    launch_hist = {launch_hist[agc_pipe_pkg::pipe_latency-2:0], lookup_valid};
    // Write lands on the outputs one edge later
    mon_eb = eb_after_write(bank_wr_en, bank_wr_sel, bank_wr_data, mon_eb);
    mon_fb = fb_after_write(bank_wr_en, bank_wr_sel, bank_wr_data, mon_fb);
  end

  // Watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout, run went past %0d cycles", cycle_limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    vec_row_t idle;
    seed         = 32'ha5dd_26cd;
    error_count  = 0;
    result_count = 0;
    cycle_count  = 0;
    drv_eb       = '0;
    drv_fb       = '0;
    mon_eb       = '0;
    mon_fb       = '0;
    launch_hist  = '0;
    idle         = '0;
    rst_l        = 1'b0;
    bank_wr_en   = 1'b0;
    bank_wr_sel  = agc_pipe_pkg::bank_eb;
    bank_wr_data = '0;
    lookup_valid = 1'b0;
    lookup_addr  = '0;

    repeat (4) @(posedge clk);
    rst_l <= 1'b1;

    // Directed table
    for (int i = 0; i < num_vectors; i++) begin
      drive_row(vectors[i]);
    end

    // Random traffic
    for (int i = 0; i < rand_cycles; i++) begin
      drive_random();
    end

    // Quiet inputs and let the pipe drain
    drive_row(idle);
    repeat (agc_pipe_pkg::pipe_latency + 1) @(posedge clk);

    assert (exp_q.size() == 0) else begin
      $display("%0d expected results never came out", exp_q.size());
      error_count++;
    end
    $display("Errors: %0d, results checked: %0d", error_count, result_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule : mem_map_tb
